// ==== hdl/adderTree.sv ====
`timescale 1ns/100ps

module adderTree
    import firPkg::*;
(
    input  logic                              clkDS,
    input  logic                              rst,
    input  logic [numGroups*partialWidth-1:0] partials,
    input  logic                              partialsValid,
    output resultT                            result,
    output logic                              resultValid
);

    resultT leafs  [numGroups];
    resultT layer1 [numGroups/2];
    resultT layer2 [numGroups/4];

    // One bit per registered layer
    logic [treeLayers-1:0] validPipe;

    // Sign-extend group sums to the output width
    always_comb begin
        for (int i = 0; i < numGroups; i++) begin
            leafs[i] = resultT'(partialT'(partials[i*partialWidth +: partialWidth]));
        end
    end

    // 8 to 4
    always_ff @(posedge clkDS) begin
        if (rst) begin
            for (int i = 0; i < numGroups/2; i++) begin
                layer1[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numGroups/2; i++) begin
                layer1[i] <= leafs[2*i] + leafs[2*i+1];
            end
        end
    end

    // 4 to 2
    always_ff @(posedge clkDS) begin
        if (rst) begin
            for (int i = 0; i < numGroups/4; i++) begin
                layer2[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numGroups/4; i++) begin
                layer2[i] <= layer1[2*i] + layer1[2*i+1];
            end
        end
    end

    // 2 to 1
    always_ff @(posedge clkDS) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= layer2[0] + layer2[1];
        end
    end

    always_ff @(posedge clkDS) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[treeLayers-2:0], partialsValid};
        end
    end

    assign resultValid = validPipe[treeLayers-1];

    validKnownChk: assert property (
        @(posedge clkDS) disable iff (rst)
        !$isunknown(resultValid)
    ) else $error("resultValid is unknown");

    // Valid leaves the tree one layer depth after it enters
    validLatencyChk: assert property (
        @(posedge clkDS) disable iff (rst)
        resultValid == $past(partialsValid, treeLayers)
    ) else $error("resultValid out of step with partialsValid");

endmodule

// ==== hdl/coefStore.sv ====
`timescale 1ns/100ps

module coefStore
    import firPkg::*;
(
    input  logic                         clkDS,
    input  logic                         rst,
    input  logic                         cfgReq,
    input  tapAddrT                      cfgAddr,
    input  coefT                         cfgData,
    output logic                         cfgAck,
    output logic [numTaps*coefWidth-1:0] coefs
);

    cfgStateT cfgState;
    coefT     coefRegs [numTaps];

    // Handshake state, hold phase is the ack
    always_ff @(posedge clkDS) begin
        if (rst) begin
            cfgState <= cfgIdle;
        end else begin
            case (cfgState)
                cfgIdle: begin
                    if (cfgReq) begin
                        cfgState <= cfgHold;
                    end
                end
                cfgHold: begin
                    if (!cfgReq) begin
                        cfgState <= cfgIdle;
                    end
                end
                default: begin
                    cfgState <= cfgIdle;
                end
            endcase
        end
    end

    assign cfgAck = (cfgState == cfgHold);

    // Single write per request, on leaving idle
    always_ff @(posedge clkDS) begin
        if (rst) begin
            for (int i = 0; i < numTaps; i++) begin
                coefRegs[i] <= '0;
            end
        end else if ((cfgState == cfgIdle) && cfgReq) begin
            coefRegs[cfgAddr] <= cfgData;
        end
    end

    always_comb begin
        for (int i = 0; i < numTaps; i++) begin
            coefs[i*coefWidth +: coefWidth] = coefRegs[i];
        end
    end

    // Master keeps cfgReq up until it sees the ack
    ackRiseChk: assert property (
        @(posedge clkDS) disable iff (rst)
        $rose(cfgAck) |-> cfgReq
    ) else $error("cfgAck rose while cfgReq was low");

endmodule

// ==== hdl/firPkg.sv ====
package firPkg;

    // Filter geometry
    localparam int sampleWidth  = 3;
    localparam int numTaps      = 16;
    localparam int tapsPerGroup = 2;
    localparam int numGroups    = numTaps / tapsPerGroup;
    localparam int treeLayers   = $clog2(numGroups);

    // Arithmetic widths
    localparam int coefWidth    = 12;
    localparam int tapAddrWidth = $clog2(numTaps);
    localparam int partialWidth = 16;
    localparam int resultWidth  = 20;

    // Modulator output code, two's complement
    typedef logic signed [sampleWidth-1:0] sampleT;

    typedef logic signed [coefWidth-1:0] coefT;

    typedef logic [tapAddrWidth-1:0] tapAddrT;

    // Sum of one group of taps
    typedef logic signed [partialWidth-1:0] partialT;

    typedef logic signed [resultWidth-1:0] resultT;

    // Four-phase config handshake
    typedef enum logic {
        cfgIdle,
        cfgHold
    } cfgStateT;

endpackage

// ==== hdl/firTop.sv ====
`timescale 1ns/100ps

module firTop
    import firPkg::*;
(
    input  logic    clkDS,
    input  logic    rst,
    input  sampleT  sampleIn,
    input  logic    sampleEn,
    input  logic    cfgReq,
    input  tapAddrT cfgAddr,
    input  coefT    cfgData,
    output logic    cfgAck,
    output resultT  result,
    output logic    resultValid
);

    logic [numTaps*coefWidth-1:0]      coefs;
    logic [numTaps*sampleWidth-1:0]    taps;
    logic                              tapsValid;
    logic [numGroups*partialWidth-1:0] partials;
    logic                              partialsValid;

    // Coefficient registers beside the datapath
    coefStore u_coefStore (
        .clkDS   (clkDS),
        .rst     (rst),
        .cfgReq  (cfgReq),
        .cfgAddr (cfgAddr),
        .cfgData (cfgData),
        .cfgAck  (cfgAck),
        .coefs   (coefs)
    );

    sampleShift u_sampleShift (
        .clkDS     (clkDS),
        .rst       (rst),
        .sampleIn  (sampleIn),
        .sampleEn  (sampleEn),
        .taps      (taps),
        .tapsValid (tapsValid)
    );

    partialSums u_partialSums (
        .clkDS         (clkDS),
        .rst           (rst),
        .taps          (taps),
        .coefs         (coefs),
        .tapsValid     (tapsValid),
        .partials      (partials),
        .partialsValid (partialsValid)
    );

    adderTree u_adderTree (
        .clkDS         (clkDS),
        .rst           (rst),
        .partials      (partials),
        .partialsValid (partialsValid),
        .result        (result),
        .resultValid   (resultValid)
    );

endmodule

// ==== hdl/partialSums.sv ====
`timescale 1ns/100ps

module partialSums
    import firPkg::*;
(
    input  logic                              clkDS,
    input  logic                              rst,
    input  logic [numTaps*sampleWidth-1:0]    taps,
    input  logic [numTaps*coefWidth-1:0]      coefs,
    input  logic                              tapsValid,
    output logic [numGroups*partialWidth-1:0] partials,
    output logic                              partialsValid
);

    sampleT  tapArr   [numTaps];
    coefT    coefArr  [numTaps];
    partialT groupSum [numGroups];

    // Unpack flat buses into signed entries
    always_comb begin
        for (int i = 0; i < numTaps; i++) begin
            tapArr[i]  = taps[i*sampleWidth +: sampleWidth];
            coefArr[i] = coefs[i*coefWidth +: coefWidth];
        end
    end

    // One multiply-add per group in place of a coefficient LUT
    always_comb begin
        for (int g = 0; g < numGroups; g++) begin
            groupSum[g] = '0;
            for (int k = 0; k < tapsPerGroup; k++) begin
                groupSum[g] = groupSum[g]
                    + tapArr[g*tapsPerGroup + k] * coefArr[g*tapsPerGroup + k];
            end
        end
    end

    always_ff @(posedge clkDS) begin
        if (rst) begin
            partials      <= '0;
            partialsValid <= 1'b0;
        end else begin
            partialsValid <= tapsValid;
            for (int g = 0; g < numGroups; g++) begin
                partials[g*partialWidth +: partialWidth] <= groupSum[g];
            end
        end
    end

endmodule

// ==== hdl/sampleShift.sv ====
`timescale 1ns/100ps

module sampleShift
    import firPkg::*;
(
    input  logic                           clkDS,
    input  logic                           rst,
    input  sampleT                         sampleIn,
    input  logic                           sampleEn,
    output logic [numTaps*sampleWidth-1:0] taps,
    output logic                           tapsValid
);

    // Saturates at numTaps
    logic [tapAddrWidth:0] fillCount;
    logic                  lineFull;

    // Line holds numTaps samples once this shift completes
    assign lineFull = (fillCount >= numTaps - 1);

    always_ff @(posedge clkDS) begin
        if (rst) begin
            taps      <= '0;
            fillCount <= '0;
            tapsValid <= 1'b0;
        end else begin
            tapsValid <= sampleEn && lineFull;
            if (sampleEn) begin
                // Newest code enters at entry 0
                taps <= {taps[(numTaps-1)*sampleWidth-1:0], sampleIn};
                if (fillCount != numTaps) begin
                    fillCount <= fillCount + 1'b1;
                end
            end
        end
    end

endmodule

// ==== sources.f ====
+incdir+include
hdl/firPkg.sv
hdl/coefStore.sv
hdl/sampleShift.sv
hdl/partialSums.sv
hdl/adderTree.sv
hdl/firTop.sv
tests/tbFir.sv

// ==== include/firRefModel.svh ====
`ifndef FIRREFMODEL_SVH
`define FIRREFMODEL_SVH

// Expected filter output, built on the firPkg types of the including scope
// history[0] is the newest sample and pairs with tap 0

function automatic resultT firRefModel(
    input coefT   coefArr [numTaps],
    input sampleT history [numTaps]
);
    resultT acc;
    acc = '0;
    for (int k = 0; k < numTaps; k++) begin
        acc = acc + history[k] * coefArr[k];
    end
    return acc;
endfunction

// Same response from a queue of accepted samples, oldest first
// Needs at least numTaps entries
function automatic resultT firRefFromQueue(
    input coefT   coefArr [numTaps],
    input sampleT samples [$]
);
    sampleT history [numTaps];
    int     last;
    last = samples.size() - 1;
    for (int k = 0; k < numTaps; k++) begin
        history[k] = samples[last - k];
    end
    return firRefModel(coefArr, history);
endfunction

`endif

// ==== tests/tbFir.sv ====
`timescale 1ns/100ps

module tbFir
    import firPkg::*;
();

    localparam int ackTimeout    = 20;
    localparam int drainTimeout  = 50;
    localparam int resultLatency = 4;
    localparam int streamLength  = 300;
    localparam int reloadLength  = 100;

    logic    clkDS;
    logic    rst;
    sampleT  sampleIn;
    logic    sampleEn;
    logic    cfgReq;
    tapAddrT cfgAddr;
    coefT    cfgData;
    logic    cfgAck;
    resultT  result;
    logic    resultValid;

    int seed       = 32'h9e8ee0db;
    int negCount   = 0;

    // Model of the DUT state
    coefT   coefArr [numTaps];
    sampleT history [$];

    // Expected results and the falling edge each one should show up on
    resultT expQ   [$];
    int     cycleQ [$];

    `include "firRefModel.svh"

    firTop u_dut (
        .clkDS       (clkDS),
        .rst         (rst),
        .sampleIn    (sampleIn),
        .sampleEn    (sampleEn),
        .cfgReq      (cfgReq),
        .cfgAddr     (cfgAddr),
        .cfgData     (cfgData),
        .cfgAck      (cfgAck),
        .result      (result),
        .resultValid (resultValid)
    );

    initial begin
        clkDS = 1'b0;
        forever #50 clkDS = ~clkDS;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkEqual(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            abortRun("Value mismatch");
        end
    endtask

    // One four-phase write, sampling cfgAck away from the driving edge
    task automatic writeCoef(input tapAddrT addr, input coefT data);
        int waitCount;
        @(posedge clkDS);
        cfgAddr <= addr;
        cfgData <= data;
        cfgReq  <= 1'b1;
        @(negedge clkDS);
        checkEqual("cfgAck", 0, cfgAck);
        waitCount = 0;
        forever begin
            @(negedge clkDS);
            if (cfgAck === 1'b1) break;
            waitCount++;
            if (waitCount > ackTimeout) abortRun("Timed out waiting for cfgAck to rise");
        end
        coefArr[addr] = data;
        @(posedge clkDS);
        cfgReq <= 1'b0;
        waitCount = 0;
        forever begin
            @(negedge clkDS);
            if (cfgAck === 1'b0) break;
            waitCount++;
            if (waitCount > ackTimeout) abortRun("Timed out waiting for cfgAck to fall");
        end
    endtask

    task automatic loadRandomCoefs();
        for (int k = 0; k < numTaps; k++) begin
            writeCoef(tapAddrT'(k), coefT'($random(seed)));
        end
    endtask

    task automatic feedSample(input sampleT value);
        @(posedge clkDS);
        sampleIn <= value;
        sampleEn <= 1'b1;
        history.push_back(value);
        if (history.size() > numTaps) history.delete(0);
        if (history.size() == numTaps) begin
            expQ.push_back(firRefFromQueue(coefArr, history));
            // Capture on the next rising edge, result seen on the falling edge after
            cycleQ.push_back(negCount + resultLatency + 2);
        end
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge clkDS);
            sampleEn <= 1'b0;
        end
    endtask

    task automatic feedRandomStream(input int count);
        for (int i = 0; i < count; i++) begin
            feedSample(sampleT'($random(seed)));
            if (($random(seed) & 3) == 0) begin
                idleCycles(1 + ($random(seed) & 3));
            end
        end
    endtask

    task automatic drainResults();
        int waitCount;
        waitCount = 0;
        forever begin
            @(posedge clkDS);
            sampleEn <= 1'b0;
            if (expQ.size() == 0) break;
            waitCount++;
            if (waitCount > drainTimeout) abortRun("Timed out waiting for pending results");
        end
    endtask

    initial begin : resultChecker
        resultT expValue;
        int     expCycle;
        forever begin
            @(negedge clkDS);
            negCount++;
            if (!rst && resultValid !== 1'b0) begin
                if (expQ.size() == 0) abortRun("resultValid was high with no result expected");
                expValue = expQ.pop_front();
                expCycle = cycleQ.pop_front();
                checkEqual("resultValid cycle", expCycle, negCount);
                checkEqual("result", expValue, result);
            end
        end
    end

    initial begin : stimulus
        coefT   minCoef;
        sampleT minSample;
        sampleT value;
        int     extremeSum;
        rst      <= 1'b1;
        sampleIn <= '0;
        sampleEn <= 1'b0;
        cfgReq   <= 1'b0;
        cfgAddr  <= '0;
        cfgData  <= '0;
        for (int k = 0; k < numTaps; k++) begin
            coefArr[k] = '0;
        end
        repeat (5) @(posedge clkDS);
        rst <= 1'b0;

        // Quiet outputs after reset
        for (int i = 0; i < 10; i++) begin
            @(negedge clkDS);
            checkEqual("cfgAck", 0, cfgAck);
            checkEqual("resultValid", 0, resultValid);
        end

        loadRandomCoefs();

        // Impulse walks through the taps in order
        for (int i = 0; i < numTaps - 1; i++) begin
            feedSample('0);
        end
        for (int k = 0; k < numTaps; k++) begin
            value = (k == 0) ? sampleT'(1) : sampleT'(0);
            feedSample(value);
            checkEqual("impulse reference", coefArr[k], firRefFromQueue(coefArr, history));
        end
        drainResults();

        feedRandomStream(streamLength);
        drainResults();

        // Largest magnitude product on every tap
        minCoef   = '0;
        minCoef[coefWidth-1] = 1'b1;
        minSample = '0;
        minSample[sampleWidth-1] = 1'b1;
        for (int k = 0; k < numTaps; k++) begin
            writeCoef(tapAddrT'(k), minCoef);
        end
        for (int i = 0; i < numTaps; i++) begin
            feedSample(minSample);
        end
        extremeSum = numTaps * (1 << (sampleWidth - 1)) * (1 << (coefWidth - 1));
        checkEqual("extreme reference", extremeSum, firRefFromQueue(coefArr, history));
        drainResults();

        loadRandomCoefs();
        feedRandomStream(reloadLength);
        drainResults();
        idleCycles(resultLatency + 2);

        $display("Regression passed");
        $finish;
    end

endmodule
